//--- hw/exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// integer datapath width
`define EXEC_XLEN 64

// gpr index width
`define EXEC_REG_AW 5

// return-address stack entries, power of two
`define EXEC_RAS_DEPTH 8

`endif

//--- hw/exec_pkg.sv
`include "exec_consts.svh"

package exec_pkg;

  typedef logic [`EXEC_XLEN-1:0] xlen_t;
  typedef logic [`EXEC_REG_AW-1:0] reg_idx_t;
  typedef logic [$clog2(`EXEC_RAS_DEPTH)-1:0] ras_ptr_t;

  // execute class from decode
  typedef enum logic [3:0] {
    EXC_NONE, EXC_LUI, EXC_AUIPC, EXC_JAL, EXC_JALR, EXC_BRANCH,
    EXC_OPIMM, EXC_OPIMM32, EXC_OP, EXC_OP32, EXC_LOAD, EXC_STORE
  } exc_op_e;

  // alu opcode, EQ..GEU drive the branch compare
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef struct packed {
    xlen_t    pc;
    exc_op_e  exc_op;
    alu_op_e  alu_op;
    reg_idx_t rs1_idx;
    reg_idx_t rd_idx;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    imm;
    logic     bpu_taken;
  } exec_uop_t;

  // operands already selected, handed from stage 1 to stage 2
  typedef struct packed {
    xlen_t    pc;
    exc_op_e  exc_op;
    alu_op_e  alu_op;
    reg_idx_t rs1_idx;
    reg_idx_t rd_idx;
    xlen_t    alu_a;
    xlen_t    alu_b;
    xlen_t    tgt_a;     // target adder inputs
    xlen_t    tgt_b;
    logic     bpu_taken;
  } exec_sel_t;

endpackage

//--- hw/exec_stage_if.sv
`timescale 1ns/1ps

interface exec_stage_if import exec_pkg::*; ();

  logic      valid;
  logic      ready;
  exec_sel_t sel;

  // producer side, stage 1
  modport src (
    output valid,
    output sel,
    input  ready
  );

  // consumer side, stage 2
  modport dst (
    input  valid,
    input  sel,
    output ready
  );

endinterface

//--- hw/exec_alu.sv
`timescale 1ns/1ps

module exec_alu import exec_pkg::*; (
  input  xlen_t   a_i,
  input  xlen_t   b_i,
  input  alu_op_e op_i,
  input  logic    word_i,   // rv64 *W forms
  output xlen_t   result_o,
  output logic    cmp_o
);

  logic [5:0]  shamt;
  logic [31:0] a_lo;
  logic [31:0] srl_w;
  logic [31:0] sra_w;
  xlen_t       sum;
  xlen_t       diff;
  logic        lt_s;
  logic        lt_u;

  assign shamt = word_i ? {1'b0, b_i[4:0]} : b_i[5:0];
  assign a_lo  = a_i[31:0];
  assign sum   = a_i + b_i;
  assign diff  = a_i - b_i;
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  // word shifts work on the low half only
  assign srl_w = a_lo >> shamt[4:0];
  assign sra_w = $signed(a_lo) >>> shamt[4:0];

  // branch condition
  always_comb begin
    case (op_i)
      ALU_EQ:  cmp_o = (a_i == b_i);
      ALU_NE:  cmp_o = (a_i != b_i);
      ALU_LT:  cmp_o = lt_s;
      ALU_GE:  cmp_o = ~lt_s;
      ALU_LTU: cmp_o = lt_u;
      ALU_GEU: cmp_o = ~lt_u;
      default: cmp_o = 1'b0;
    endcase
  end

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = sum;
      ALU_SUB:  result_o = diff;
      ALU_SLL:  result_o = a_i << shamt;   // low word is right for SLLW too
      ALU_SLT:  result_o = xlen_t'(lt_s);
      ALU_SLTU: result_o = xlen_t'(lt_u);
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SRL:  result_o = word_i ? {32'b0, srl_w} : a_i >> shamt;
      ALU_SRA: begin
        if (word_i) result_o = {{32{sra_w[31]}}, sra_w};
        else result_o = $signed(a_i) >>> shamt;
      end
      ALU_OR:   result_o = a_i | b_i;
      ALU_AND:  result_o = a_i & b_i;
      default:  result_o = xlen_t'(cmp_o);  // compare ops
    endcase
  end

endmodule

//--- hw/exec_branch_resolve.sv
`timescale 1ns/1ps

module exec_branch_resolve import exec_pkg::*; (
  input  exc_op_e  exc_op_i,
  input  logic     cmp_i,
  input  logic     bpu_taken_i,
  input  reg_idx_t rs1_idx_i,
  input  reg_idx_t rd_idx_i,
  input  xlen_t    tgt_a_i,
  input  xlen_t    tgt_b_i,
  output logic     redirect_valid_o,
  output xlen_t    redirect_pc_o,
  output logic     push_o,
  output logic     pop_o,
  output logic     ras_ptr_valid_o
);

  logic is_branch;
  logic is_jal;
  logic is_jalr;
  logic taken;
  logic mispredict;
  logic rd_link;
  logic rs1_link;

  assign is_branch = (exc_op_i == EXC_BRANCH);
  assign is_jal    = (exc_op_i == EXC_JAL);
  assign is_jalr   = (exc_op_i == EXC_JALR);

  // jumps always go, branches only when the compare holds
  assign taken      = (is_branch & cmp_i) | is_jal | is_jalr;
  assign mispredict = taken ^ bpu_taken_i;

  assign redirect_valid_o = mispredict;
  assign redirect_pc_o    = tgt_a_i + tgt_b_i;

  // x1 and x5 are the link registers
  assign rd_link  = (rd_idx_i == reg_idx_t'(1)) | (rd_idx_i == reg_idx_t'(5));
  assign rs1_link = (rs1_idx_i == reg_idx_t'(1)) | (rs1_idx_i == reg_idx_t'(5));

  assign push_o = (is_jal | is_jalr) & rd_link;  // call
  assign pop_o  = is_jalr & rs1_link;            // return

  // bpu only needs the stack pointer back on a wrong branch
  assign ras_ptr_valid_o = mispredict & is_branch;

endmodule

//--- hw/exec_ras_ptr.sv
`timescale 1ns/1ps

module exec_ras_ptr import exec_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     en_i,
  input  logic     push_i,
  input  logic     pop_i,
  output ras_ptr_t ptr_o
);

  ras_ptr_t ptr_q;

  // pointer width sets the wrap, no explicit modulo
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (en_i) begin
      case ({push_i, pop_i})
        2'b10:   ptr_q <= ptr_q + 1'b1;
        2'b01:   ptr_q <= ptr_q - 1'b1;
        default: ptr_q <= ptr_q;  // pop then push nets out
      endcase
    end
  end

  assign ptr_o = ptr_q;

endmodule

//--- hw/exec_operand_sel.sv
`timescale 1ns/1ps

module exec_operand_sel import exec_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  exec_uop_t uop_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  exec_stage_if.src out
);

  exec_sel_t sel_d;
  exec_sel_t sel_q;
  logic      valid_q;
  xlen_t     imm_hi;    // imm with low 12 bits cleared
  logic      accept;

  assign imm_hi = {uop_i.imm[63:12], 12'b0};

  always_comb begin
    sel_d.pc        = uop_i.pc;
    sel_d.exc_op    = uop_i.exc_op;
    sel_d.alu_op    = uop_i.alu_op;
    sel_d.rs1_idx   = uop_i.rs1_idx;
    sel_d.rd_idx    = uop_i.rd_idx;
    sel_d.bpu_taken = uop_i.bpu_taken;
    case (uop_i.exc_op)
      EXC_OP, EXC_OP32, EXC_BRANCH: begin
        sel_d.alu_a = uop_i.rs1_data;
        sel_d.alu_b = uop_i.rs2_data;
      end
      EXC_OPIMM, EXC_OPIMM32, EXC_LOAD, EXC_STORE: begin
        sel_d.alu_a = uop_i.rs1_data;
        sel_d.alu_b = uop_i.imm;
      end
      EXC_JAL, EXC_JALR: begin // link value
        sel_d.alu_a = uop_i.pc;
        sel_d.alu_b = xlen_t'(4);
      end
      EXC_AUIPC: begin
        sel_d.alu_a = uop_i.pc;
        sel_d.alu_b = imm_hi;
      end
      EXC_LUI: begin
        sel_d.alu_a = '0;
        sel_d.alu_b = imm_hi;
      end
      default: begin
        sel_d.alu_a = '0;
        sel_d.alu_b = '0;
      end
    endcase
    // predicted taken means the fix-up target is the fall-through pc
    if (uop_i.bpu_taken) begin
      sel_d.tgt_a = uop_i.pc;
      sel_d.tgt_b = xlen_t'(4);
    end else begin
      sel_d.tgt_a = (uop_i.exc_op == EXC_JALR) ? uop_i.rs1_data : uop_i.pc;
      sel_d.tgt_b = uop_i.imm;
    end
  end

  assign in_ready_o = ~valid_q | out.ready;
  assign accept     = in_valid_i & in_ready_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;  // empties when downstream takes it
    end
  end

  always_ff @(posedge clk) begin
    if (accept) sel_q <= sel_d;
  end

  assign out.valid = valid_q;
  assign out.sel   = sel_q;

endmodule

//--- hw/exec_alu_stage.sv
`timescale 1ns/1ps

module exec_alu_stage import exec_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  exec_stage_if.dst in,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output xlen_t    out_pc_o,
  output reg_idx_t out_rd_o,
  output xlen_t    out_result_o,
  output logic     redirect_valid_o,
  output xlen_t    redirect_pc_o,
  output ras_ptr_t ras_ptr_o,
  output logic     ras_ptr_valid_o
);

  xlen_t alu_res;
  xlen_t result;
  logic  cmp;
  logic  word;
  logic  redir_vld, redir_vld_q;
  xlen_t redir_pc;
  logic  push, push_q;
  logic  pop, pop_q;
  logic  ras_vld, ras_vld_q;
  logic  valid_q;

  assign word = (in.sel.exc_op == EXC_OPIMM32) | (in.sel.exc_op == EXC_OP32);

  exec_alu u_alu (
    .a_i      (in.sel.alu_a),
    .b_i      (in.sel.alu_b),
    .op_i     (in.sel.alu_op),
    .word_i   (word),
    .result_o (alu_res),
    .cmp_o    (cmp)
  );

  exec_branch_resolve u_branch (
    .exc_op_i (in.sel.exc_op), .cmp_i (cmp), .bpu_taken_i (in.sel.bpu_taken),
    .rs1_idx_i (in.sel.rs1_idx), .rd_idx_i (in.sel.rd_idx),
    .tgt_a_i (in.sel.tgt_a), .tgt_b_i (in.sel.tgt_b),
    .redirect_valid_o (redir_vld), .redirect_pc_o (redir_pc),
    .push_o (push), .pop_o (pop), .ras_ptr_valid_o (ras_vld)
  );

  assign result   = word ? {{32{alu_res[31]}}, alu_res[31:0]} : alu_res;
  assign in.ready = ~valid_q | out_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) valid_q <= 1'b0;
    else if (in.ready) valid_q <= in.valid;
  end

  always_ff @(posedge clk) begin
    if (in.valid & in.ready) begin
      out_pc_o     <= in.sel.pc;
      out_rd_o     <= in.sel.rd_idx;
      out_result_o <= result;
      redir_vld_q  <= redir_vld;
      redirect_pc_o <= redir_pc;
      ras_vld_q    <= ras_vld;
      push_q       <= push;
      pop_q        <= pop;
    end
  end

  // stack pointer moves only when the item leaves
  exec_ras_ptr u_ras_ptr (
    .clk (clk), .rst_n_i (rst_n_i), .en_i (valid_q & out_ready_i),
    .push_i (push_q), .pop_i (pop_q), .ptr_o (ras_ptr_o)
  );

  assign out_valid_o      = valid_q;
  assign redirect_valid_o = valid_q & redir_vld_q;
  assign ras_ptr_valid_o  = valid_q & ras_vld_q;

endmodule

//--- hw/exec_top.sv
`timescale 1ns/1ps

module exec_top import exec_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  // micro-op in
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  xlen_t    pc_i,
  input  exc_op_e  exc_op_i,
  input  alu_op_e  alu_op_i,
  input  reg_idx_t rs1_idx_i,
  input  reg_idx_t rd_idx_i,
  input  xlen_t    rs1_data_i,
  input  xlen_t    rs2_data_i,
  input  xlen_t    imm_i,
  input  logic     bpu_taken_i,
  // result out
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output xlen_t    out_pc_o,
  output reg_idx_t out_rd_o,
  output xlen_t    out_result_o,
  // to pc gen and bpu
  output logic     redirect_valid_o,
  output xlen_t    redirect_pc_o,
  output ras_ptr_t ras_ptr_o,
  output logic     ras_ptr_valid_o
);

  exec_uop_t uop;

  assign uop = '{pc: pc_i, exc_op: exc_op_i, alu_op: alu_op_i,
                 rs1_idx: rs1_idx_i, rd_idx: rd_idx_i,
                 rs1_data: rs1_data_i, rs2_data: rs2_data_i,
                 imm: imm_i, bpu_taken: bpu_taken_i};

  exec_stage_if stage_if ();

  exec_operand_sel u_operand_sel (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .uop_i      (uop),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .out        (stage_if)
  );

  exec_alu_stage u_alu_stage (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .in               (stage_if),
    .out_valid_o      (out_valid_o),
    .out_ready_i      (out_ready_i),
    .out_pc_o         (out_pc_o),
    .out_rd_o         (out_rd_o),
    .out_result_o     (out_result_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o),
    .ras_ptr_o        (ras_ptr_o),
    .ras_ptr_valid_o  (ras_ptr_valid_o)
  );

endmodule

//--- sim/exec_clk_gen.sv
`timescale 1ns/1ps

module exec_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;  // 4 ns period
  end

  // reset held over four rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

//--- sim/exec_chk.sv
`timescale 1ns/1ps

module exec_chk import exec_pkg::*; (
  input logic     clk,
  input logic     rst_n_i,
  input logic     out_valid_i,
  input logic     out_ready_i,
  input xlen_t    out_pc_i,
  input reg_idx_t out_rd_i,
  input xlen_t    out_result_i,
  input logic     redirect_valid_i,
  input xlen_t    redirect_pc_i,
  input ras_ptr_t ras_ptr_i,
  input logic     ras_ptr_valid_i
);

  int fail_cnt = 0;

  // sync reset, valid clears one edge later
  a_reset_clears: assert property (@(posedge clk) !rst_n_i |=> !out_valid_i)
    else begin
      $error("out_valid_o still high after a reset cycle");
      fail_cnt++;
    end

  a_hold_fields: assert property (@(posedge clk) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=> $stable({out_pc_i, out_rd_i, out_result_i,
      redirect_valid_i, redirect_pc_i, ras_ptr_i, ras_ptr_valid_i}))
    else begin
      $error("output fields changed while stalled");
      fail_cnt++;
    end

  // pointer restore only comes with a redirect
  a_ptr_needs_redirect: assert property (@(posedge clk) disable iff (!rst_n_i)
    ras_ptr_valid_i |-> redirect_valid_i)
    else begin
      $error("ras_ptr_valid_o without redirect_valid_o");
      fail_cnt++;
    end

  a_valid_holds: assert property (@(posedge clk) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=> out_valid_i)
    else begin
      $error("out_valid_o dropped before out_ready_i");
      fail_cnt++;
    end

endmodule

//--- sim/exec_tb.sv
`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

  typedef struct {
    exc_op_e  exc;
    alu_op_e  alu;
    xlen_t    pc;
    reg_idx_t rs1_idx;
    reg_idx_t rd_idx;
    xlen_t    rs1;
    xlen_t    rs2;
    xlen_t    imm;
    logic     bpu;
    xlen_t    exp_res;
    logic     exp_redir;
    xlen_t    exp_rpc;
    logic     exp_pv;
  } row_t;

  localparam xlen_t all_ones = '1;
  localparam xlen_t top_bit  = 64'h8000_0000_0000_0000;

  logic clk, rst_n;
  logic in_valid_i, in_ready_o, bpu_taken_i;
  xlen_t pc_i, rs1_data_i, rs2_data_i, imm_i;
  exc_op_e exc_op_i;
  alu_op_e alu_op_i;
  reg_idx_t rs1_idx_i, rd_idx_i, out_rd_o;
  logic out_valid_o, out_ready_i, redirect_valid_o, ras_ptr_valid_o;
  xlen_t out_pc_o, out_result_o, redirect_pc_o;
  ras_ptr_t ras_ptr_o;
  ras_ptr_t ptr_model = '0;
  row_t rows[$];
  row_t cur;
  int err_cnt = 0;
  int out_cnt = 0;
  integer seed = 32'h9bbc;

  exec_clk_gen u_clk_gen (.clk_o (clk), .rst_n_o (rst_n));

  exec_top exec_top_inst (.*, .rst_n_i (rst_n));

  bind exec_top exec_chk u_chk (
    .clk (clk), .rst_n_i (rst_n_i), .out_valid_i (out_valid_o), .out_ready_i (out_ready_i),
    .out_pc_i (out_pc_o), .out_rd_i (out_rd_o), .out_result_i (out_result_o),
    .redirect_valid_i (redirect_valid_o), .redirect_pc_i (redirect_pc_o),
    .ras_ptr_i (ras_ptr_o), .ras_ptr_valid_i (ras_ptr_valid_o)
  );

  task automatic add_row(exc_op_e exc, alu_op_e alu, xlen_t pc, reg_idx_t rs1_idx,
      reg_idx_t rd_idx, xlen_t rs1, xlen_t rs2, xlen_t imm, logic bpu,
      xlen_t res, logic redir, xlen_t rpc, logic pv);
    rows.push_back('{exc, alu, pc, rs1_idx, rd_idx, rs1, rs2, imm, bpu, res, redir, rpc, pv});
  endtask

  task automatic check_xlen(string name, xlen_t got, xlen_t exp);
    if (got !== exp) begin
      $display("Error %s got %h expected %h (row %0d)", name, got, exp, out_cnt);
      err_cnt++;
    end
  endtask

  task automatic check_reg(string name, reg_idx_t got, reg_idx_t exp);
    if (got !== exp) begin
      $display("Error %s got %h expected %h (row %0d)", name, got, exp, out_cnt);
      err_cnt++;
    end
  endtask

  task automatic check_ptr(string name, ras_ptr_t got, ras_ptr_t exp);
    if (got !== exp) begin
      $display("Error %s got %h expected %h (row %0d)", name, got, exp, out_cnt);
      err_cnt++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Error %s got %h expected %h (row %0d)", name, got, exp, out_cnt);
      err_cnt++;
    end
  endtask

  // call pushes and return pops on the x1 and x5 link registers
  function automatic ras_ptr_t next_ras_ptr(ras_ptr_t p, row_t r);
    logic link_rd;
    logic link_rs1;
    link_rd  = (r.rd_idx == 1) || (r.rd_idx == 5);
    link_rs1 = (r.rs1_idx == 1) || (r.rs1_idx == 5);
    if ((r.exc == EXC_JAL || r.exc == EXC_JALR) && link_rd) p = p + 3'd1;
    if (r.exc == EXC_JALR && link_rs1) p = p - 3'd1;
    return p;
  endfunction

  task automatic drive_row(row_t r);
    in_valid_i  = 1'b1;
    exc_op_i    = r.exc;
    alu_op_i    = r.alu;
    pc_i        = r.pc;
    rs1_idx_i   = r.rs1_idx;
    rd_idx_i    = r.rd_idx;
    rs1_data_i  = r.rs1;
    rs2_data_i  = r.rs2;
    imm_i       = r.imm;
    bpu_taken_i = r.bpu;
    do @(negedge clk); while (!in_ready_o);  // ready is settled mid-cycle
    @(posedge clk);
    #1;
  endtask

  // ready high about three cycles in four
  always @(posedge clk) begin
    #1;
    out_ready_i = ($random(seed) & 3) != 0;
  end

  // handshake seen mid-cycle completes on the next rising edge
  always @(negedge clk) begin
    if (rst_n && out_valid_o && out_ready_i) begin
      if (out_cnt >= rows.size()) begin
        $display("an output arrived after the last table row had left");
        err_cnt++;
      end else begin
        cur = rows[out_cnt];
        check_xlen("out_pc_o", out_pc_o, cur.pc);
        check_reg("out_rd_o", out_rd_o, cur.rd_idx);
        check_xlen("out_result_o", out_result_o, cur.exp_res);
        check_bit("redirect_valid_o", redirect_valid_o, cur.exp_redir);
        if (cur.exp_redir) check_xlen("redirect_pc_o", redirect_pc_o, cur.exp_rpc);
        check_bit("ras_ptr_valid_o", ras_ptr_valid_o, cur.exp_pv);
        check_ptr("ras_ptr_o", ras_ptr_o, ptr_model);  // value before this item's update
        ptr_model = next_ras_ptr(ptr_model, cur);
      end
      out_cnt++;
    end
  end

  initial begin
    in_valid_i = 1'b0;
    out_ready_i = 1'b0;
    bpu_taken_i = 1'b0;
    exc_op_i = EXC_NONE;
    alu_op_i = ALU_ADD;
    pc_i = '0;
    rs1_idx_i = '0;
    rd_idx_i = '0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    imm_i = '0;
    // exc, alu, pc, rs1_idx, rd_idx, rs1, rs2, imm, bpu, result, redirect, redirect pc, ptr valid
    add_row(EXC_OP, ALU_ADD, 'h100, 2, 3, 'h7, 'h5, 0, 0, 'hc, 0, 0, 0);
    add_row(EXC_OP, ALU_SUB, 'h104, 2, 3, 'h5, 'h7, 0, 0, all_ones - 1, 0, 0, 0);
    add_row(EXC_OPIMM, ALU_SLL, 'h108, 2, 3, 'h1, 0, 'h3f, 0, top_bit, 0, 0, 0);
    add_row(EXC_OP, ALU_SRA, 'h10c, 2, 3, top_bit, 'h4, 0, 0, 64'hf800_0000_0000_0000, 0, 0, 0);
    add_row(EXC_OP, ALU_SLT, 'h110, 2, 3, all_ones, 'h1, 0, 0, 'h1, 0, 0, 0);
    add_row(EXC_OP, ALU_SLTU, 'h114, 2, 3, all_ones, 'h1, 0, 0, 'h0, 0, 0, 0);
    add_row(EXC_OPIMM, ALU_XOR, 'h118, 2, 3, 'hff00, 0, 'h0ff0, 0, 'hf0f0, 0, 0, 0);
    add_row(EXC_OP, ALU_OR, 'h11c, 2, 3, 'hf0, 'h0f, 0, 0, 'hff, 0, 0, 0);
    add_row(EXC_OPIMM, ALU_AND, 'h120, 2, 3, 'hff, 0, 'h3c, 0, 'h3c, 0, 0, 0);
    add_row(EXC_OP32, ALU_ADD, 'h124, 2, 3, 'h7fff_ffff, 'h1, 0, 0, all_ones << 31, 0, 0, 0);
    add_row(EXC_OPIMM32, ALU_SRL, 'h128, 2, 3, all_ones << 31, 0, 'h4, 0, 'h0800_0000, 0, 0, 0);
    add_row(EXC_OP32, ALU_SRA, 'h12c, 2, 3, 'h1_8000_0000, 'h4, 0, 0, all_ones << 27, 0, 0, 0);
    add_row(EXC_LUI, ALU_ADD, 'h130, 0, 3, 'hdead, 0, 'h1234_5fff, 0, 'h1234_5000, 0, 0, 0);
    add_row(EXC_AUIPC, ALU_ADD, 'h134, 0, 3, 0, 0, 'h2abc, 0, 'h2134, 0, 0, 0);
    add_row(EXC_LOAD, ALU_ADD, 'h138, 2, 3, 'h1000, 0, all_ones - 7, 0, 'hff8, 0, 0, 0);
    add_row(EXC_STORE, ALU_ADD, 'h13c, 2, 0, 'h2000, 'h55, 'h10, 0, 'h2010, 0, 0, 0);
    add_row(EXC_BRANCH, ALU_EQ, 'h140, 2, 0, 'h5, 'h5, 'h40, 0, 'h1, 1, 'h180, 1);
    add_row(EXC_BRANCH, ALU_NE, 'h144, 2, 0, 'h5, 'h5, 'h40, 1, 'h0, 1, 'h148, 1);
    add_row(EXC_BRANCH, ALU_LT, 'h148, 2, 0, all_ones, 'h1, 'h40, 1, 'h1, 0, 0, 0);
    add_row(EXC_BRANCH, ALU_GEU, 'h14c, 2, 0, 'h1, all_ones, 'h40, 0, 'h0, 0, 0, 0);
    add_row(EXC_JAL, ALU_ADD, 'h150, 0, 1, 0, 0, 'h100, 0, 'h154, 1, 'h250, 0);
    add_row(EXC_JALR, ALU_ADD, 'h154, 1, 0, 'h800, 0, 'h10, 0, 'h158, 1, 'h810, 0);
    for (int k = 0; k < 9; k++) begin  // nine nested calls wrap the pointer
      add_row(EXC_JAL, ALU_ADD, 'h200 + 4 * k, 0, 1, 0, 0, 'h100, 1, 'h204 + 4 * k, 0, 0, 0);
    end
    add_row(EXC_JALR, ALU_ADD, 'h300, 5, 1, 'h400, 0, 0, 1, 'h304, 0, 0, 0);
    add_row(EXC_JALR, ALU_ADD, 'h304, 1, 0, 'h308, 0, 0, 1, 'h308, 0, 0, 0);
    add_row(EXC_NONE, ALU_ADD, 'h308, 0, 0, 'h77, 'h99, 'h5, 0, 'h0, 0, 0, 0);

    // budget of 40 cycles per row plus reset
    fork
      begin
        repeat (rows.size() * 40 + 4) @(posedge clk);
        $display("timeout: only %0d of %0d results left the DUT", out_cnt, rows.size());
        $display("tests failed");
        $finish;
      end
    join_none

    @(posedge rst_n);
    @(posedge clk);
    #1;
    check_bit("in_ready_o", in_ready_o, 1'b1);  // empty pipe accepts
    foreach (rows[i]) drive_row(rows[i]);
    in_valid_i = 1'b0;
    while (out_cnt < rows.size()) @(posedge clk);
    repeat (4) @(posedge clk);  // catch stray extra outputs
    $display("errors: %0d compare, %0d assertion", err_cnt, exec_top_inst.u_chk.fail_cnt);
    if (err_cnt == 0 && exec_top_inst.u_chk.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- exec_core.f
+incdir+hw
hw/exec_pkg.sv
hw/exec_stage_if.sv
hw/exec_alu.sv
hw/exec_branch_resolve.sv
hw/exec_ras_ptr.sv
hw/exec_operand_sel.sv
hw/exec_alu_stage.sv
hw/exec_top.sv
sim/exec_clk_gen.sv
sim/exec_chk.sv
sim/exec_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := exec_tb
FLIST     := exec_core.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
RUN_ARGS  := +verilator+error+limit+1000
SRCS      := $(wildcard hw/*.sv hw/*.svh sim/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
